//--- font.mem
// logo at 0x380: 4 rows of 2 bytes (columns 0-7, then 8-15)
// font at 0x400: 8 glyphs of 8 row bytes, bit n of a byte is pixel column n
@380
ff 0f
81 09
81 09
ff 0f
@400
00 00 00 00 00 00 00 00  // glyph 0 blank
18 1c 18 18 18 18 7e 00  // glyph 1
3c 66 60 30 0c 06 7e 00  // glyph 2
3c 66 60 38 60 66 3c 00  // glyph 3
30 38 34 32 7e 30 30 00  // glyph 4
7e 06 3e 60 60 66 3c 00  // glyph 5
3c 06 3e 66 66 66 3c 00  // glyph 6
ff 81 81 81 81 81 81 ff  // glyph 7 box, fallback

//--- compile.f
src/textdisp_pkg.sv
src/scan_if.sv
src/scan_timing.sv
src/glyph_mem.sv
src/text_renderer.sv
src/textdisp_top.sv
tb/textdisp_properties.sv
tb/textdisp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# verilator build and run of the text display testbench
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module textdisp_tb \
    -f compile.f -o textdisp_sim
./obj_dir/textdisp_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- tb/textdisp_tb.sv
//******************************
// lfsr register writes, screen model and colour checks
//******************************
`timescale 1ns/1ps

module textdisp_tb;
    localparam int cycles_per_pixel = 4;
    localparam int h_total          = 272;
    localparam int v_total          = 232;
    localparam int logo_x           = 120;
    localparam int logo_y           = 210;
    localparam int frame_limit      = h_total * v_total * cycles_per_pixel + 64;

    typedef struct packed {
        int                   due;    // cycle the colour should appear in
        logic [7:0]           x;
        logic [7:0]           y;
        textdisp_pkg::color_t color;
    } pend_t;

    logic                 hclk;
    logic                 rst_n;
    logic [3:0]           reg_char_we;
    logic [31:0]          reg_char_di;
    textdisp_pkg::color_t color;
    logic                 color_valid;
    logic [7:0]           pix_x;
    logic [7:0]           pix_y;
    logic                 frame_start;
    logic [7:0]           font_img [0:2047];    // logo and font image as loaded in the dut
    logic [7:0]           screen [0:27][0:31];  // char buffer model
    logic [15:0]          lfsr;
    pend_t                pend_q [$];           // pixels still owed a colour
    pend_t                pend;
    logic [7:0]           prev_x;
    logic [7:0]           prev_y;
    logic [7:0]           exp_x;                // raster position the next pixel should have
    logic [7:0]           exp_y;
    int                   last_pix;             // cycle of the previous pixel
    int                   cyc;
    int                   checked;
    int                   errors;
    bit                   ok;

    textdisp_top #(
        .cycles_per_pixel (cycles_per_pixel),
        .h_total          (h_total),
        .v_total          (v_total),
        .logo_x           (logo_x),
        .logo_y           (logo_y)
    ) textdisp_top_inst (.*);

    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;  // 100 ns period
    end

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // expected pixel from logo window, buffer and font rules
    function automatic textdisp_pkg::color_t expect_color(input logic [7:0] x, y);
        int         lx;
        int         ly;
        logic [7:0] code;
        logic [7:0] bits;
        logic [2:0] glyph;
        lx = int'(x) - logo_x;
        ly = int'(y) - logo_y;
        if (lx >= 0 && lx < 16 && ly >= 0 && ly < 4) begin
            bits = font_img[int'(textdisp_pkg::logo_base) + ly * 2 + lx / 8];  // logo on top
            return bits[lx % 8] ? textdisp_pkg::color_logo : textdisp_pkg::color_back;
        end
        code  = screen[y / 8][x / 8];
        glyph = code[7] ? textdisp_pkg::glyph_fallback : code[2:0];
        bits  = font_img[int'(textdisp_pkg::font_base) + int'(glyph) * 8 + int'(y % 8)];
        if (!bits[x % 8]) begin
            return textdisp_pkg::color_back;
        end
        return (x < 8) ? textdisp_pkg::color_cursor : textdisp_pkg::color_text;
    endfunction

    // about one access in 16 cycles with some bad commands or lane 0 off
    task automatic drive_random_write();
        logic [7:0] cmd;
        logic [4:0] col;
        logic [4:0] row;
        if (rand_bits(4) != 0) begin
            reg_char_we = 4'b0000;
        end else begin
            cmd         = (rand_bits(3) == 0) ? 8'(rand_bits(8)) : 8'(textdisp_pkg::cmd_put_char);
            col         = 5'(rand_bits(5));
            row         = 5'(rand_bits(5) % 28);                 // rows 0..27 only
            reg_char_we = 4'(rand_bits(4)) | {3'b000, rand_bits(2) != 0};
            reg_char_di = {cmd, 3'b000, col, 3'b000, row, 8'(rand_bits(8))};
        end
    endtask

    // runs until the next frame_start with inputs moved 1 ns after each edge
    task automatic run_frame(input bit writes, output bit done);
        int n;
        n    = 0;
        done = 1'b0;
        while (!done && n < frame_limit) begin
            @(posedge hclk);
            #1;
            n++;
            if (writes) begin
                drive_random_write();
            end else begin
                reg_char_we = 4'b0000;
            end
            done = frame_start && n > 1;
        end
        if (!done) begin
            errors++;
            $display("no frame_start within %0d cycles", frame_limit);
        end
    endtask

    // model runs mid-cycle when dut outputs and tb inputs have settled
    always @(negedge hclk) begin
        if (!rst_n) begin
            cyc      = 0;
            prev_x   = 8'd0;
            prev_y   = 8'd0;
            exp_x    = 8'd0;
            exp_y    = 8'd0;
            last_pix = 0;
            pend_q.delete();
            for (int r = 0; r < 28; r++) begin
                for (int c = 0; c < 32; c++) begin
                    screen[r][c] = 8'h00;
                end
            end
        end else begin
            cyc++;
            if (color_valid) begin
                if (pend_q.size() == 0) begin
                    errors++;
                    $display("color_valid with no pixel waiting, cycle %0d", cyc);
                end else begin
                    pend = pend_q.pop_front();
                    checked++;
                    if (pend.due != cyc) begin
                        errors++;
                        $display("colour for x %0d y %0d came at cycle %0d, due at %0d",
                                 pend.x, pend.y, cyc, pend.due);
                    end
                    if (color !== pend.color) begin
                        errors++;
                        $display("Fail color exp %h got %h at x %h y %h",
                                 pend.color, color, pend.x, pend.y);
                    end
                end
            end else if (pend_q.size() != 0 && pend_q[0].due < cyc) begin
                pend = pend_q.pop_front();
                errors++;
                $display("no colour came for pixel x %0d y %0d", pend.x, pend.y);
            end
            // new pixel when the position moves or frame_start marks the first one
            if (frame_start || pix_x != prev_x || pix_y != prev_y) begin
                if ((pix_x == 8'd0 && pix_y == 8'd0) != frame_start) begin
                    errors++;
                    $display("frame_start out of step with position (0,0)");
                end
                if (pix_x !== exp_x) begin
                    errors++;
                    $display("Fail pix_x exp %h got %h", exp_x, pix_x);
                end
                if (pix_y !== exp_y) begin
                    errors++;
                    $display("Fail pix_y exp %h got %h", exp_y, pix_y);
                end
                // pixels inside a row are evenly spaced
                if (exp_x != 8'd0 && cyc - last_pix != cycles_per_pixel) begin
                    errors++;
                    $display("pixel x %0d y %0d came %0d cycles after the one before",
                             exp_x, exp_y, cyc - last_pix);
                end
                last_pix   = cyc;
                pend.due   = cyc + 3;
                pend.x     = exp_x;
                pend.y     = exp_y;
                pend.color = expect_color(exp_x, exp_y);  // before this cycle's write
                pend_q.push_back(pend);
                exp_x = exp_x + 8'd1;                     // wraps at the row end
                if (exp_x == 8'd0) begin
                    exp_y = (exp_y == 8'd223) ? 8'd0 : exp_y + 8'd1;
                end
            end
            prev_x = pix_x;
            prev_y = pix_y;
            // lands on the next edge after the char read of this pixel
            if (reg_char_we[0] && reg_char_di[31:24] == 8'(textdisp_pkg::cmd_put_char)) begin
                screen[reg_char_di[12:8]][reg_char_di[20:16]] = {1'b0, reg_char_di[6:0]};
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        reg_char_we = 4'b0000;
        reg_char_di = 32'h0000_0000;
        lfsr        = 16'd58;
        errors      = 0;
        checked     = 0;
        $readmemh("font.mem", font_img);
        repeat (3) @(posedge hclk);
        #1;
        rst_n = 1'b1;
        run_frame(1'b0, ok);      // frame 1 with an empty buffer
        if (ok) begin
            run_frame(1'b1, ok);  // frame 2 with writes while scanning
        end
        if (ok) begin
            run_frame(1'b0, ok);  // frame 3 on a quiet bus
        end
        if (ok && checked < 3 * 256 * 224) begin
            errors++;
            $display("only %0d colours checked in three frames", checked);
        end
        $display("errors %0d, colours checked %0d", errors, checked);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tb/textdisp_properties.sv
//******************************
// renderer fsm and colour strobe assertions
//******************************
`timescale 1ns/1ps

module textdisp_properties (
    input logic       hclk,
    input logic       rst_n,
    input logic [1:0] state,  // renderer fsm: idle, font, logo, output
    input logic       color_valid
);
    localparam logic [1:0] st_fetch_font = 2'd1;
    localparam logic [1:0] st_fetch_logo = 2'd2;
    localparam logic [1:0] st_output     = 2'd3;

    // either fetch goes straight to output
    fetch_to_output: assert property (@(posedge hclk) disable iff (!rst_n)
        (state == st_fetch_font || state == st_fetch_logo) |=> (state == st_output))
        else $error("fetch state not followed by output state");

    valid_single: assert property (@(posedge hclk) disable iff (!rst_n)
        color_valid |=> !color_valid)
        else $error("color_valid high on two cycles in a row");

    // sync reset, so cleared from the edge after rst_n is seen low
    valid_in_reset: assert property (@(posedge hclk) !rst_n |=> !color_valid)
        else $error("color_valid high during reset");
endmodule

bind text_renderer textdisp_properties props_inst (
    .hclk        (hclk),
    .rst_n       (rst_n),
    .state       (state),
    .color_valid (color_valid)
);

//--- src/textdisp_top.sv
//******************************
// text display top: scan, memory, renderer
//******************************
`timescale 1ns/1ps

module textdisp_top #(
    parameter int cycles_per_pixel = 4,
    parameter int h_total          = 272,
    parameter int v_total          = 232,
    parameter int logo_x           = 120,
    parameter int logo_y           = 210
) (
    input  logic                   hclk,
    input  logic                   rst_n,
    input  logic [3:0]             reg_char_we,  // register write strobes
    input  logic [31:0]            reg_char_di,
    output textdisp_pkg::color_t   color,
    output logic                   color_valid,
    output logic [7:0]             pix_x,        // position being scanned
    output logic [7:0]             pix_y,
    output logic                   frame_start
);
    scan_if scan ();

    textdisp_pkg::mem_addr_t rd_addr;
    logic [7:0]              rd_data;

    scan_timing #(
        .cycles_per_pixel (cycles_per_pixel),
        .h_total          (h_total),
        .v_total          (v_total)
    ) u_scan (
        .hclk  (hclk),
        .rst_n (rst_n),
        .scan  (scan.src)
    );

    glyph_mem u_mem (
        .hclk        (hclk),
        .reg_char_we (reg_char_we),
        .reg_char_di (reg_char_di),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    text_renderer #(
        .logo_x (logo_x),
        .logo_y (logo_y)
    ) u_render (
        .hclk        (hclk),
        .rst_n       (rst_n),
        .scan        (scan.dst),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .color       (color),
        .color_valid (color_valid)
    );

    // observers attribute each colour to this position
    assign pix_x       = scan.x;
    assign pix_y       = scan.y;
    assign frame_start = scan.frame_start;

endmodule

//--- src/text_renderer.sv
//******************************
// pixel fetch fsm: char, font/logo, colour
//******************************
`timescale 1ns/1ps

module text_renderer #(
    parameter int logo_x = 120,  // logo window origin
    parameter int logo_y = 210
) (
    input  logic                      hclk,
    input  logic                      rst_n,
    scan_if.dst                       scan,
    input  logic [7:0]                rd_data,
    output textdisp_pkg::mem_addr_t   rd_addr,
    output textdisp_pkg::color_t      color,
    output logic                      color_valid
);
    localparam int logo_w = 16;
    localparam int logo_h = 4;

    typedef enum logic [1:0] {
        st_idle,        // wait for pixel, char address on the bus
        st_fetch_font,  // char code back, ask for glyph row
        st_fetch_logo,  // ask for logo byte
        st_output       // byte back, pick the bit
    } state_t;

    state_t                    state;
    logic [7:0]                lx;
    logic [7:0]                ly;
    logic                      in_logo;
    logic [2:0]                glyph;
    logic                      pix_bit;
    textdisp_pkg::mem_addr_t   char_addr;
    logic                      logo_sel;   // this pixel comes from the logo
    logic [2:0]                logo_byte;  // {row, half}
    logic [2:0]                logo_off;
    logic [2:0]                x_off;
    logic                      cursor;

    // position relative to the logo origin
    assign lx = scan.x - 8'(logo_x);
    assign ly = scan.y - 8'(logo_y);

    assign in_logo = (int'(scan.x) >= logo_x) && (int'(scan.x) < logo_x + logo_w) &&
                     (int'(scan.y) >= logo_y) && (int'(scan.y) < logo_y + logo_h);

    assign char_addr = textdisp_pkg::char_base + {1'b0, scan.y[7:3], scan.x[7:3]};
    // only 8 glyphs in the rom
    assign glyph     = rd_data[7] ? textdisp_pkg::glyph_fallback : rd_data[2:0];
    assign pix_bit   = logo_sel ? rd_data[logo_off] : rd_data[x_off];

    // read address follows the state
    always_comb begin
        case (state)
            st_fetch_font: rd_addr = textdisp_pkg::font_base + {5'd0, glyph, scan.y[2:0]};
            st_fetch_logo: rd_addr = textdisp_pkg::logo_base + {8'd0, logo_byte};
            default:       rd_addr = char_addr;
        endcase
    end

    // per-pixel values worked out while the char byte is read
    always_ff @(posedge hclk) begin
        if (state == st_idle && scan.pix_valid) begin
            logo_sel  <= in_logo;
            logo_byte <= {ly[1:0], lx[3]};
            logo_off  <= lx[2:0];
            x_off     <= scan.x[2:0];
            cursor    <= scan.x[7:3] == 5'd0;  // leftmost cell column
        end
    end

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            state       <= st_idle;
            color       <= textdisp_pkg::color_back;
            color_valid <= 1'b0;
        end else begin
            color_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (scan.pix_valid) begin
                        state <= in_logo ? st_fetch_logo : st_fetch_font;
                    end
                end
                st_fetch_font, st_fetch_logo: state <= st_output;
                st_output: begin
                    state       <= st_idle;
                    color_valid <= 1'b1;  // 3 cycles after pix_valid
                    if (logo_sel) begin
                        color <= pix_bit ? textdisp_pkg::color_logo : textdisp_pkg::color_back;
                    end else if (pix_bit) begin
                        color <= cursor ? textdisp_pkg::color_cursor : textdisp_pkg::color_text;
                    end else begin
                        color <= textdisp_pkg::color_back;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- src/glyph_mem.sv
//******************************
// char buffer + logo + font ram
//******************************
`timescale 1ns/1ps

module glyph_mem (
    input  logic                      hclk,
    input  logic [3:0]                reg_char_we,  // only lane 0 is decoded
    input  logic [31:0]               reg_char_di,
    input  textdisp_pkg::mem_addr_t   rd_addr,
    output logic [7:0]                rd_data
);
    localparam int depth = 1 << $bits(textdisp_pkg::mem_addr_t);

    logic [7:0]                mem [0:depth-1];
    logic [7:0]                cmd;
    logic [4:0]                cell_row;
    logic [4:0]                cell_col;
    logic                      wr_en;
    textdisp_pkg::mem_addr_t   wr_addr;
    logic [7:0]                wr_data;

    // logo and font images, char buffer starts out zero
    initial begin
        $readmemh("font.mem", mem);
    end

    // register word: [31:24] cmd, [20:16] col, [12:8] row, [6:0] char
    assign cmd      = reg_char_di[31:24];
    assign cell_col = reg_char_di[20:16];
    assign cell_row = reg_char_di[12:8];
    assign wr_data  = {1'b0, reg_char_di[6:0]};  // bit 7 never stored

    assign wr_en   = reg_char_we[0] && (cmd == {6'd0, textdisp_pkg::cmd_put_char});
    // rows 28..31 land past the buffer, not used by software
    assign wr_addr = textdisp_pkg::char_base + {1'b0, cell_row, cell_col};

    // port a writes, port b reads; same-cycle hit returns the old byte
    always_ff @(posedge hclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

//--- src/scan_timing.sv
//******************************
// raster walker, one strobe per pixel
//******************************
`timescale 1ns/1ps

module scan_timing #(
    parameter int cycles_per_pixel = 4,  // >= 4, renderer needs the room
    parameter int h_total          = 272,
    parameter int v_total          = 232
) (
    input  logic hclk,
    input  logic rst_n,
    scan_if.src  scan
);
    localparam int h_active = 256;
    localparam int v_active = 224;
    localparam int div_w    = $clog2(cycles_per_pixel);
    localparam int h_w      = $clog2(h_total);
    localparam int v_w      = $clog2(v_total);

    logic [div_w-1:0] div_cnt;  // cycles within one pixel
    logic [h_w-1:0]   h_cnt;    // raster column incl. blanking
    logic [v_w-1:0]   v_cnt;    // raster row incl. blanking
    logic             div_last;
    logic             h_last;
    logic             v_last;
    logic             pix_start;

    assign div_last  = int'(div_cnt) == cycles_per_pixel - 1;
    assign h_last    = int'(h_cnt) == h_total - 1;
    assign v_last    = int'(v_cnt) == v_total - 1;
    // first cycle of a pixel inside the visible area
    assign pix_start = (div_cnt == '0) && (int'(h_cnt) < h_active) && (int'(v_cnt) < v_active);

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            div_cnt          <= '0;
            h_cnt            <= '0;
            v_cnt            <= '0;
            scan.x           <= '0;
            scan.y           <= '0;
            scan.pix_valid   <= 1'b0;
            scan.frame_start <= 1'b0;
        end else begin
            scan.pix_valid   <= pix_start;
            scan.frame_start <= pix_start && (h_cnt == '0) && (v_cnt == '0);
            if (pix_start) begin
                scan.x <= h_cnt[7:0];  // x/y only move on visible pixels
                scan.y <= v_cnt[7:0];
            end
            if (div_last) begin
                div_cnt <= '0;
                if (h_last) begin
                    h_cnt <= '0;
                    v_cnt <= v_last ? '0 : v_cnt + 1'b1;  // wrap to next frame
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- src/scan_if.sv
//******************************
// raster position and pixel strobes
//******************************
`timescale 1ns/1ps

interface scan_if;
    logic [7:0] x;            // active column 0..255
    logic [7:0] y;            // active row 0..223
    logic       pix_valid;    // one pulse per active pixel
    logic       frame_start;  // with the pixel at (0,0)

    // scan generator side
    modport src (
        output x, y, pix_valid, frame_start
    );

    // renderer side
    modport dst (
        input x, y, pix_valid, frame_start
    );
endinterface

//--- src/textdisp_pkg.sv
//******************************
// memory map, colours and command code of the text display
//******************************

package textdisp_pkg;

    // 2 KB shared memory, byte addressed
    typedef logic [10:0] mem_addr_t;

    // char buffer: 32x28 cells, {row, col}
    localparam mem_addr_t char_base = 11'h000;
    // logo rom: 2 bytes per row, 4 rows
    localparam mem_addr_t logo_base = 11'h380;
    // font rom: {glyph, row}, bit n = pixel column n
    localparam mem_addr_t font_base = 11'h400;

    // pixel in bgr 5:5:5
    typedef logic [14:0] color_t;

    localparam color_t color_back   = 15'b00000_00000_00000;  // black
    localparam color_t color_text   = 15'b10000_11111_11111;  // yellow
    localparam color_t color_cursor = 15'b10000_11000_11111;  // orange
    localparam color_t color_logo   = 15'b00000_10011_11111;

    // command field sits in reg_char_di[31:24]
    localparam logic [1:0] cmd_put_char = 2'd0;

    // codes >= 0x80 fall back to the last glyph
    localparam logic [2:0] glyph_fallback = 3'd7;

endpackage
